/* tcdm_bus_pkg.sv */
package tcdm_bus_pkg;

  // ------------------------------------------------------------------------
  // bank word geometry
  // ------------------------------------------------------------------------

  localparam int unsigned data_width = 32;
  localparam int unsigned be_width = data_width / 8;

  // cycles between an SRAM read strobe and valid read data
  localparam int unsigned sram_rd_latency = 1;

  // one data word of the bank
  typedef logic [data_width-1:0] data_t;

  // one enable bit per byte lane
  typedef logic [be_width-1:0] be_t;

endpackage

/* amo_pkg.sv */
package amo_pkg;

  // ------------------------------------------------------------------------
  // atomic opcodes as carried on the request bus
  // ------------------------------------------------------------------------

  typedef enum logic [3:0] {
    amo_none = 4'h0,
    amo_swap = 4'h1,
    amo_add  = 4'h2,
    amo_and  = 4'h3,
    amo_or   = 4'h4,
    amo_xor  = 4'h5,
    amo_max  = 4'h6,
    amo_maxu = 4'h7,
    amo_min  = 4'h8,
    amo_minu = 4'h9,
    amo_lr   = 4'hA,
    amo_sc   = 4'hB
  } amo_op_e;

  // read-modify-write sequencing
  typedef enum logic [1:0] {
    idle,
    do_amo,
    write_back
  } amo_state_e;

  // words returned for a store-conditional
  localparam logic [31:0] sc_success = 32'h0000_0000;
  localparam logic [31:0] sc_failure = 32'h0000_0001;

endpackage

/* tcdm_req_if.sv */
interface tcdm_req_if #(
  parameter int unsigned addr_width = 16,
  parameter int unsigned meta_width = 8
);

  import tcdm_bus_pkg::*;
  import amo_pkg::*;

  // single-cycle strobe for an accepted request
  logic                  fire;
  amo_op_e               op;
  logic                  write;
  logic [addr_width-1:0] addr;
  data_t                 wdata;
  be_t                   be;
  logic [meta_width-1:0] meta;
  // reservation verdict, only meaningful for an SC
  logic                  sc_ok;

  modport dec (
    output fire, op, write, addr, wdata, be, meta, sc_ok
  );

  modport exe (
    input fire, op, write, addr, wdata, be, meta, sc_ok
  );

endinterface

/* tcdm_rsp_if.sv */
interface tcdm_rsp_if #(
  parameter int unsigned meta_width = 8
);

  import tcdm_bus_pkg::*;

  // metadata comes in the acceptance cycle
  logic                  meta_push;
  logic [meta_width-1:0] meta;
  // data follows exactly one cycle later
  logic                  data_push;
  data_t                 data;

  modport exe (
    output meta_push, meta, data_push, data
  );

  modport res (
    input meta_push, meta, data_push, data
  );

endinterface

/* tcdm_reservation.sv */
module tcdm_reservation #(
  parameter int unsigned addr_width = 16,
  parameter int unsigned meta_width = 8,
  parameter int unsigned num_resv   = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  fire_i,
  input  amo_pkg::amo_op_e      op_i,
  input  logic                  write_i,
  input  logic [addr_width-1:0] addr_i,
  input  logic [meta_width-1:0] meta_i,
  output logic                  sc_ok_o
);

  import amo_pkg::*;

  localparam int unsigned idx_width = (num_resv > 1) ? $clog2(num_resv) : 1;

  logic [num_resv-1:0]   valid_q, valid_d;
  logic [addr_width-1:0] addr_q [num_resv];
  logic [meta_width-1:0] meta_q [num_resv];

  logic [num_resv-1:0]   meta_hit;
  logic [num_resv-1:0]   addr_hit;
  logic                  lr_found;
  logic [idx_width-1:0]  lr_idx;
  logic                  lr_take;
  logic                  wr_commit;
  logic                  is_plain;

  // ------------------------------------------------------------------------
  // lookup
  // ------------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < num_resv; i++) begin
      meta_hit[i] = valid_q[i] && (meta_q[i] == meta_i);
      addr_hit[i] = valid_q[i] && (addr_q[i] == addr_i);
    end
  end

  assign sc_ok_o = |(meta_hit & addr_hit);

  // an LR refreshes its own entry first, else takes the lowest free one
  always_comb begin
    lr_found = 1'b0;
    lr_idx   = '0;
    for (int i = 0; i < num_resv; i++) begin
      if (!lr_found && meta_hit[i]) begin
        lr_found = 1'b1;
        lr_idx   = idx_width'(i);
      end
    end
    for (int i = 0; i < num_resv; i++) begin
      if (!lr_found && !valid_q[i]) begin
        lr_found = 1'b1;
        lr_idx   = idx_width'(i);
      end
    end
  end

  assign is_plain  = !(op_i inside {[amo_swap:amo_minu], amo_lr, amo_sc});
  assign lr_take   = fire_i && (op_i == amo_lr) && lr_found;
  assign wr_commit = (is_plain && write_i) || (op_i inside {[amo_swap:amo_minu]}) ||
                     ((op_i == amo_sc) && sc_ok_o);

  // ------------------------------------------------------------------------
  // update
  // ------------------------------------------------------------------------

  // a successful SC hits its own address, so the write clear consumes it
  always_comb begin
    valid_d = valid_q;
    if (fire_i && wr_commit) begin
      valid_d = valid_q & ~addr_hit;
    end
    if (lr_take) begin
      valid_d[lr_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lr_take) begin
      addr_q[lr_idx] <= addr_i;
      meta_q[lr_idx] <= meta_i;
    end
  end

endmodule

/* tcdm_decode.sv */
module tcdm_decode #(
  parameter int unsigned addr_width = 16,
  parameter int unsigned meta_width = 8,
  parameter int unsigned num_resv   = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [addr_width-1:0] in_address_i,
  input  logic [3:0]            in_amo_i,
  input  logic                  in_write_i,
  input  tcdm_bus_pkg::data_t   in_wdata_i,
  input  logic [meta_width-1:0] in_meta_i,
  input  tcdm_bus_pkg::be_t     in_be_i,
  input  logic                  busy_i,
  input  logic                  rsp_full_i,
  tcdm_req_if.dec               req
);

  import amo_pkg::*;

  amo_op_e op;
  logic    fire;
  logic    sc_ok;

  // hold off while an atomic owns the bank or the response path is blocked
  assign in_ready_o = !busy_i && !rsp_full_i;
  assign fire       = in_valid_i && in_ready_o;
  assign op         = amo_op_e'(in_amo_i);

  tcdm_reservation #(
    .addr_width (addr_width),
    .meta_width (meta_width),
    .num_resv   (num_resv)
  ) i_reservation (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .fire_i  (fire),
    .op_i    (op),
    .write_i (in_write_i),
    .addr_i  (in_address_i),
    .meta_i  (in_meta_i),
    .sc_ok_o (sc_ok)
  );

  assign req.fire  = fire;
  assign req.op    = op;
  assign req.write = in_write_i;
  assign req.addr  = in_address_i;
  assign req.wdata = in_wdata_i;
  assign req.be    = in_be_i;
  assign req.meta  = in_meta_i;
  assign req.sc_ok = sc_ok;

endmodule

/* tcdm_amo_alu.sv */
module tcdm_amo_alu (
  input  amo_pkg::amo_op_e    op_i,
  input  tcdm_bus_pkg::data_t mem_i,
  input  tcdm_bus_pkg::data_t operand_i,
  output tcdm_bus_pkg::data_t result_o
);

  import tcdm_bus_pkg::*;
  import amo_pkg::*;

  logic                signed_cmp;
  logic                sub;
  logic [data_width:0] opa, opb, opb_x, sum;
  logic                less;

  // one extra bit so the carry out doubles as the compare result
  assign signed_cmp = op_i inside {amo_max, amo_min};
  assign sub        = op_i inside {amo_max, amo_maxu, amo_min, amo_minu};

  assign opa   = {signed_cmp & mem_i[data_width-1], mem_i};
  assign opb   = {signed_cmp & operand_i[data_width-1], operand_i};
  assign opb_x = sub ? ~opb : opb;
  assign sum   = opa + opb_x + {{data_width{1'b0}}, sub};

  // mem < operand
  assign less = sum[data_width];

  always_comb begin
    unique case (op_i)
      amo_add:            result_o = sum[data_width-1:0];
      amo_and:            result_o = mem_i & operand_i;
      amo_or:             result_o = mem_i | operand_i;
      amo_xor:            result_o = mem_i ^ operand_i;
      amo_max, amo_maxu:  result_o = less ? operand_i : mem_i;
      amo_min, amo_minu:  result_o = less ? mem_i : operand_i;
      // swap and everything else stores the operand
      default:            result_o = operand_i;
    endcase
  end

endmodule

/* tcdm_execute.sv */
module tcdm_execute #(
  parameter int unsigned addr_width   = 16,
  parameter bit          register_amo = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  tcdm_req_if.exe               req,
  tcdm_rsp_if.exe               rsp,
  output logic                  busy_o,
  output logic                  out_req_o,
  output logic [addr_width-1:0] out_add_o,
  output logic                  out_write_o,
  output tcdm_bus_pkg::data_t   out_wdata_o,
  output tcdm_bus_pkg::be_t     out_be_o,
  input  tcdm_bus_pkg::data_t   out_rdata_i
);

  import tcdm_bus_pkg::*;
  import amo_pkg::*;

  amo_state_e            state_q, state_d;
  amo_op_e               amo_op_q;
  logic [addr_width-1:0] amo_addr_q;
  data_t                 amo_operand_q;
  data_t                 amo_result, amo_result_q;

  logic is_amo, is_lr, is_sc, is_plain;
  logic commit;
  logic meta_push;

  logic [sram_rd_latency-1:0] push_q, sc_q, sc_ok_q;

  assign is_amo   = req.op inside {[amo_swap:amo_minu]};
  assign is_lr    = req.op == amo_lr;
  assign is_sc    = req.op == amo_sc;
  assign is_plain = !(is_amo || is_lr || is_sc);

  // ------------------------------------------------------------------------
  // SRAM side
  // ------------------------------------------------------------------------

  // write slot of the read-modify-write
  assign commit = ((state_q == do_amo) && !register_amo) || (state_q == write_back);

  always_comb begin
    // a failed SC never reaches the bank
    out_req_o   = req.fire && !(is_sc && !req.sc_ok);
    out_add_o   = req.addr;
    out_write_o = (is_plain && req.write) || is_sc;
    out_wdata_o = req.wdata;
    out_be_o    = req.be;
    if (commit) begin
      out_req_o   = 1'b1;
      out_add_o   = amo_addr_q;
      out_write_o = 1'b1;
      out_wdata_o = register_amo ? amo_result_q : amo_result;
      out_be_o    = '1;
    end
  end

  // ------------------------------------------------------------------------
  // atomic sequencing
  // ------------------------------------------------------------------------

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      idle:       if (req.fire && is_amo) state_d = do_amo;
      do_amo:     state_d = register_amo ? write_back : idle;
      write_back: state_d = idle;
      default:    state_d = idle;
    endcase
  end

  assign busy_o = state_q != idle;

  tcdm_amo_alu i_amo_alu (
    .op_i      (amo_op_q),
    .mem_i     (out_rdata_i),
    .operand_i (amo_operand_q),
    .result_o  (amo_result)
  );

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req.fire && is_amo) begin
      amo_op_q      <= req.op;
      amo_addr_q    <= req.addr;
      amo_operand_q <= req.wdata;
    end
    // old data is on out_rdata_i only in do_amo
    if (state_q == do_amo) begin
      amo_result_q <= amo_result;
    end
  end

  // ------------------------------------------------------------------------
  // response pushes
  // ------------------------------------------------------------------------

  // everything except a plain store answers
  assign meta_push     = req.fire && !(is_plain && req.write);
  assign rsp.meta_push = meta_push;
  assign rsp.meta      = req.meta;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q  <= '0;
      sc_q    <= '0;
      sc_ok_q <= '0;
    end else begin
      push_q[0]  <= meta_push;
      sc_q[0]    <= req.fire && is_sc;
      sc_ok_q[0] <= req.sc_ok;
      for (int i = 1; i < sram_rd_latency; i++) begin
        push_q[i]  <= push_q[i-1];
        sc_q[i]    <= sc_q[i-1];
        sc_ok_q[i] <= sc_ok_q[i-1];
      end
    end
  end

  assign rsp.data_push = push_q[sram_rd_latency-1];
  assign rsp.data      = !sc_q[sram_rd_latency-1]   ? out_rdata_i :
                         sc_ok_q[sram_rd_latency-1] ? sc_success  : sc_failure;

endmodule

/* tcdm_result.sv */
module tcdm_result #(
  parameter int unsigned meta_width = 8
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  tcdm_rsp_if.res               rsp,
  output logic                  full_o,
  output logic                  in_valid_o,
  input  logic                  in_ready_i,
  output tcdm_bus_pkg::data_t   in_rdata_o,
  output logic [meta_width-1:0] in_meta_o
);

  import tcdm_bus_pkg::*;

  logic [meta_width-1:0] meta_q [2];
  logic                  wr_ptr_q, rd_ptr_q;
  logic [1:0]            count_q;

  data_t data_q;
  logic  data_valid_q;
  logic  data_store;
  logic  pop;

  // data falls through in the cycle it is pushed
  assign in_valid_o = (count_q != 2'd0) && (data_valid_q || rsp.data_push);
  assign in_rdata_o = data_valid_q ? data_q : rsp.data;
  assign in_meta_o  = meta_q[rd_ptr_q];
  assign pop        = in_valid_o && in_ready_i;

  // no new request while the head is stalled or the queue is full
  assign full_o = (in_valid_o && !in_ready_i) || (count_q == 2'd2);

  // keep pushed data unless it leaves right away
  assign data_store = rsp.data_push && (data_valid_q || !pop);

  // ------------------------------------------------------------------------
  // metadata queue
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (rsp.meta_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      unique case ({rsp.meta_push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp.meta_push) begin
      meta_q[wr_ptr_q] <= rsp.meta;
    end
  end

  // ------------------------------------------------------------------------
  // data register
  // ------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_valid_q <= 1'b0;
    end else if (data_store) begin
      data_valid_q <= 1'b1;
    end else if (pop) begin
      data_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (data_store) begin
      data_q <= rsp.data;
    end
  end

endmodule

/* tcdm_adapter.sv */
module tcdm_adapter #(
  parameter int unsigned addr_width   = 16,
  parameter int unsigned meta_width   = 8,
  parameter int unsigned num_resv     = 4,
  parameter bit          register_amo = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // request side
  input  logic                  in_valid_i,
  output logic                  in_ready_o,
  input  logic [addr_width-1:0] in_address_i,
  input  logic [3:0]            in_amo_i,
  input  logic                  in_write_i,
  input  tcdm_bus_pkg::data_t   in_wdata_i,
  input  logic [meta_width-1:0] in_meta_i,
  input  tcdm_bus_pkg::be_t     in_be_i,
  // response side
  output logic                  in_valid_o,
  input  logic                  in_ready_i,
  output tcdm_bus_pkg::data_t   in_rdata_o,
  output logic [meta_width-1:0] in_meta_o,
  // SRAM side
  output logic                  out_req_o,
  output logic [addr_width-1:0] out_add_o,
  output logic                  out_write_o,
  output tcdm_bus_pkg::data_t   out_wdata_o,
  output tcdm_bus_pkg::be_t     out_be_o,
  input  tcdm_bus_pkg::data_t   out_rdata_i
);

  logic busy;
  logic rsp_full;

  tcdm_req_if #(
    .addr_width (addr_width),
    .meta_width (meta_width)
  ) req_if ();

  tcdm_rsp_if #(
    .meta_width (meta_width)
  ) rsp_if ();

  tcdm_decode #(
    .addr_width (addr_width),
    .meta_width (meta_width),
    .num_resv   (num_resv)
  ) i_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .in_valid_i   (in_valid_i),
    .in_ready_o   (in_ready_o),
    .in_address_i (in_address_i),
    .in_amo_i     (in_amo_i),
    .in_write_i   (in_write_i),
    .in_wdata_i   (in_wdata_i),
    .in_meta_i    (in_meta_i),
    .in_be_i      (in_be_i),
    .busy_i       (busy),
    .rsp_full_i   (rsp_full),
    .req          (req_if.dec)
  );

  tcdm_execute #(
    .addr_width   (addr_width),
    .register_amo (register_amo)
  ) i_execute (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req         (req_if.exe),
    .rsp         (rsp_if.exe),
    .busy_o      (busy),
    .out_req_o   (out_req_o),
    .out_add_o   (out_add_o),
    .out_write_o (out_write_o),
    .out_wdata_o (out_wdata_o),
    .out_be_o    (out_be_o),
    .out_rdata_i (out_rdata_i)
  );

  tcdm_result #(
    .meta_width (meta_width)
  ) i_result (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .rsp        (rsp_if.res),
    .full_o     (rsp_full),
    .in_valid_o (in_valid_o),
    .in_ready_i (in_ready_i),
    .in_rdata_o (in_rdata_o),
    .in_meta_o  (in_meta_o)
  );

endmodule

/* tb_clk_gen.sv */
module tb_clk_gen #(
  parameter int unsigned period       = 4,
  parameter int unsigned reset_cycles = 10
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(period / 2) clk_o = ~clk_o;
  end

  // reset released on a rising edge after the hold time
  initial begin
    rst_no = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

/* tcdm_adapter_asserts.sv */
module tcdm_adapter_asserts #(
  parameter int unsigned meta_width   = 8,
  parameter bit          register_amo = 1'b0
) (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  in_valid_i,
  input logic                  in_ready_o,
  input logic [3:0]            in_amo_i,
  input logic                  in_valid_o,
  input logic                  in_ready_i,
  input tcdm_bus_pkg::data_t   in_rdata_o,
  input logic [meta_width-1:0] in_meta_o,
  input logic                  out_req_o,
  input logic                  out_write_o,
  input tcdm_bus_pkg::be_t     out_be_o
);

  import amo_pkg::*;

  // extra cycle before the write when the result is registered
  localparam int unsigned wr_gap = register_amo ? 1 : 0;

  // a response held back by the requester keeps its data and metadata
  stalled_rsp_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (in_valid_o && !in_ready_i) |=> (in_valid_o && $stable(in_rdata_o) && $stable(in_meta_o))
  ) else $error("stalled response changed");

  no_req_in_reset: assert property (
    @(posedge clk_i) !rst_ni |-> !out_req_o
  ) else $error("SRAM request during reset");

  // the bank belongs to an accepted atomic up to and including its write slot
  amo_write_blocks: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (in_valid_i && in_ready_o && (in_amo_i inside {[amo_swap:amo_minu]}))
      |=> !in_ready_o ##wr_gap
          (!in_ready_o && out_req_o && out_write_o && (out_be_o == '1))
  ) else $error("atomic write slot missing or request accepted during it");

endmodule

bind tcdm_adapter tcdm_adapter_asserts #(
  .meta_width   (meta_width),
  .register_amo (register_amo)
) i_asserts (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .in_valid_i  (in_valid_i),
  .in_ready_o  (in_ready_o),
  .in_amo_i    (in_amo_i),
  .in_valid_o  (in_valid_o),
  .in_ready_i  (in_ready_i),
  .in_rdata_o  (in_rdata_o),
  .in_meta_o   (in_meta_o),
  .out_req_o   (out_req_o),
  .out_write_o (out_write_o),
  .out_be_o    (out_be_o)
);

/* tb_tcdm_adapter.sv */
module tb_tcdm_adapter #(
  parameter bit register_amo = 1'b0
);

  import tcdm_bus_pkg::*;
  import amo_pkg::*;

  localparam int unsigned addr_width     = 16;
  localparam int unsigned meta_width     = 8;
  localparam int unsigned num_resv       = 4;
  localparam int unsigned timeout_cycles = 200;

  typedef struct {
    string                 name;
    amo_op_e               op;
    logic                  write;
    logic [addr_width-1:0] addr;
    data_t                 wdata;
    be_t                   be;
    logic [meta_width-1:0] meta;
    int                    stall;
  } entry_t;

  logic                  clk_i, rst_ni;
  logic                  in_valid_i, in_ready_o, in_write_i;
  logic [addr_width-1:0] in_address_i;
  logic [3:0]            in_amo_i;
  data_t                 in_wdata_i;
  logic [meta_width-1:0] in_meta_i;
  be_t                   in_be_i;
  logic                  in_valid_o, in_ready_i;
  data_t                 in_rdata_o;
  logic [meta_width-1:0] in_meta_o;
  logic                  out_req_o, out_write_o;
  logic [addr_width-1:0] out_add_o;
  data_t                 out_wdata_o, out_rdata_i;
  be_t                   out_be_o;

  data_t sram_mem [2**addr_width];
  data_t ref_mem [2**addr_width];

  // reference reservation table
  logic                  rv [num_resv];
  logic [addr_width-1:0] ra [num_resv];
  logic [meta_width-1:0] rm [num_resv];

  entry_t                table_q [$];
  data_t                 exp_data [$];
  logic [meta_width-1:0] exp_meta [$];
  string                 exp_name [$];
  int                    exp_stall [$];

  integer seed = 32'h51cb_bcdf;
  int     rsp_errors, mem_errors, timeouts;
  int     wait_cnt;
  logic   ready_next;

  tb_clk_gen #(.period (4), .reset_cycles (10)) i_clk_gen (.clk_o (clk_i), .rst_no (rst_ni));

  tcdm_adapter #(
    .addr_width   (addr_width),
    .meta_width   (meta_width),
    .num_resv     (num_resv),
    .register_amo (register_amo)
  ) dut (.*);

  // ------------------------------------------------------------------------
  // SRAM model, read data one cycle after the strobe
  // ------------------------------------------------------------------------

  always @(posedge clk_i) begin
    if (out_req_o) begin
      if (out_write_o) begin
        for (int b = 0; b < be_width; b++) begin
          if (out_be_o[b]) sram_mem[out_add_o][8*b +: 8] <= out_wdata_o[8*b +: 8];
        end
      end else begin
        out_rdata_i <= sram_mem[out_add_o];
      end
    end
  end

  function automatic data_t fill_word(int unsigned a);
    return {a[15:0] ^ 16'ha5c3, a[15:0]};
  endfunction

  function automatic data_t merge_be(data_t old, data_t nw, be_t be);
    data_t r;
    r = old;
    for (int b = 0; b < be_width; b++) begin
      if (be[b]) r[8*b +: 8] = nw[8*b +: 8];
    end
    return r;
  endfunction

  // new memory value of a read-modify-write per the RISC-V rules
  function automatic data_t amo_expect(amo_op_e op, data_t old, data_t opnd);
    case (op)
      amo_add:  return old + opnd;
      amo_and:  return old & opnd;
      amo_or:   return old | opnd;
      amo_xor:  return old ^ opnd;
      amo_max:  return ($signed(old) > $signed(opnd)) ? old : opnd;
      amo_maxu: return (old > opnd) ? old : opnd;
      amo_min:  return ($signed(old) < $signed(opnd)) ? old : opnd;
      amo_minu: return (old < opnd) ? old : opnd;
      default:  return opnd;
    endcase
  endfunction

  task automatic add_entry(string name, amo_op_e op, logic wr, logic [15:0] addr,
                           data_t wdata, be_t be, logic [7:0] meta);
    entry_t e;
    e.name  = name;
    e.op    = op;
    e.write = wr;
    e.addr  = addr;
    e.wdata = wdata;
    e.be    = be;
    e.meta  = meta;
    e.stall = $unsigned($random(seed)) % 4;
    table_q.push_back(e);
  endtask

  task automatic build_table();
    add_entry("store_a", amo_none, 1'b1, 16'h0010, 32'hdead_beef, 4'hf, 8'h01);
    add_entry("load_a", amo_none, 1'b0, 16'h0010, 32'h0, 4'hf, 8'h02);
    add_entry("amo_swap", amo_swap, 1'b0, 16'h0100, 32'h1111_2222, 4'hf, 8'h10);
    add_entry("chk_swap", amo_none, 1'b0, 16'h0100, 32'h0, 4'hf, 8'h11);
    add_entry("amo_add", amo_add, 1'b0, 16'h0104, 32'h0000_0fff, 4'hf, 8'h12);
    add_entry("chk_add", amo_none, 1'b0, 16'h0104, 32'h0, 4'hf, 8'h13);
    add_entry("amo_and", amo_and, 1'b0, 16'h0108, 32'h0f0f_0f0f, 4'hf, 8'h14);
    add_entry("chk_and", amo_none, 1'b0, 16'h0108, 32'h0, 4'hf, 8'h15);
    add_entry("amo_or", amo_or, 1'b0, 16'h010c, 32'h8000_0001, 4'hf, 8'h16);
    add_entry("chk_or", amo_none, 1'b0, 16'h010c, 32'h0, 4'hf, 8'h17);
    add_entry("amo_xor", amo_xor, 1'b0, 16'h0110, 32'hffff_ffff, 4'hf, 8'h18);
    add_entry("chk_xor", amo_none, 1'b0, 16'h0110, 32'h0, 4'hf, 8'h19);
    add_entry("amo_max", amo_max, 1'b0, 16'h0114, 32'h7fff_0000, 4'hf, 8'h1a);
    add_entry("chk_max", amo_none, 1'b0, 16'h0114, 32'h0, 4'hf, 8'h1b);
    add_entry("amo_maxu", amo_maxu, 1'b0, 16'h0118, 32'h7fff_0000, 4'hf, 8'h1c);
    add_entry("chk_maxu", amo_none, 1'b0, 16'h0118, 32'h0, 4'hf, 8'h1d);
    add_entry("amo_min", amo_min, 1'b0, 16'h011c, 32'h0000_0005, 4'hf, 8'h1e);
    add_entry("chk_min", amo_none, 1'b0, 16'h011c, 32'h0, 4'hf, 8'h1f);
    add_entry("amo_minu", amo_minu, 1'b0, 16'h0120, 32'h0000_0005, 4'hf, 8'h20);
    add_entry("chk_minu", amo_none, 1'b0, 16'h0120, 32'h0, 4'hf, 8'h21);
    // LR/SC pair that should succeed
    add_entry("lr_ok", amo_lr, 1'b0, 16'h0030, 32'h0, 4'hf, 8'h03);
    add_entry("sc_ok", amo_sc, 1'b0, 16'h0030, 32'h0000_1234, 4'hf, 8'h03);
    add_entry("chk_sc_ok", amo_none, 1'b0, 16'h0030, 32'h0, 4'hf, 8'h04);
    add_entry("sc_no_resv", amo_sc, 1'b0, 16'h0034, 32'h5555_aaaa, 4'hf, 8'h04);
    add_entry("chk_no_resv", amo_none, 1'b0, 16'h0034, 32'h0, 4'hf, 8'h05);
    // another master breaks the reservation
    add_entry("lr_broken", amo_lr, 1'b0, 16'h0038, 32'h0, 4'hf, 8'h05);
    add_entry("store_other", amo_none, 1'b1, 16'h0038, 32'h0bad_f00d, 4'hf, 8'h06);
    add_entry("sc_broken", amo_sc, 1'b0, 16'h0038, 32'h7777_7777, 4'hf, 8'h05);
    add_entry("chk_broken", amo_none, 1'b0, 16'h0038, 32'h0, 4'hf, 8'h07);
    add_entry("store_half", amo_none, 1'b1, 16'h003c, 32'hcafe_babe, 4'h3, 8'h08);
    add_entry("load_half", amo_none, 1'b0, 16'h003c, 32'h0, 4'hf, 8'h09);
    add_entry("load_fill", amo_none, 1'b0, 16'hf00d, 32'h0, 4'hf, 8'h0a);
  endtask

  // ------------------------------------------------------------------------
  // reference model, applied in acceptance order
  // ------------------------------------------------------------------------

  task automatic clear_resv(logic [addr_width-1:0] addr);
    for (int i = 0; i < num_resv; i++) begin
      if (rv[i] && ra[i] == addr) rv[i] = 1'b0;
    end
  endtask

  task automatic apply_reference(entry_t e);
    data_t old;
    logic  ok;
    int    idx;
    old = ref_mem[e.addr];
    ok  = 1'b0;
    idx = -1;
    if (e.op inside {[amo_swap:amo_minu]}) begin
      ref_mem[e.addr] = amo_expect(e.op, old, e.wdata);
      clear_resv(e.addr);
      exp_data.push_back(old);
    end else if (e.op == amo_lr) begin
      for (int i = 0; i < num_resv; i++) begin
        if (idx < 0 && rv[i] && rm[i] == e.meta) idx = i;
      end
      for (int i = 0; i < num_resv; i++) begin
        if (idx < 0 && !rv[i]) idx = i;
      end
      if (idx >= 0) begin
        rv[idx] = 1'b1;
        ra[idx] = e.addr;
        rm[idx] = e.meta;
      end
      exp_data.push_back(old);
    end else if (e.op == amo_sc) begin
      for (int i = 0; i < num_resv; i++) begin
        if (rv[i] && ra[i] == e.addr && rm[i] == e.meta) ok = 1'b1;
      end
      if (ok) begin
        ref_mem[e.addr] = merge_be(old, e.wdata, e.be);
        clear_resv(e.addr);
      end
      exp_data.push_back(ok ? 32'h0 : 32'h1);
    end else if (e.write) begin
      ref_mem[e.addr] = merge_be(old, e.wdata, e.be);
      clear_resv(e.addr);
      return;
    end else begin
      exp_data.push_back(old);
    end
    exp_meta.push_back(e.meta);
    exp_name.push_back(e.name);
    exp_stall.push_back(e.stall);
  endtask

  task automatic check_response();
    if (exp_data.size() == 0) begin
      $display("response with meta %h arrived with no request pending", in_meta_o);
      rsp_errors++;
    end else begin
      if (in_rdata_o !== exp_data[0]) begin
        $display("MISMATCH %s data expected %h actual %h", exp_name[0], exp_data[0],
                 in_rdata_o);
        rsp_errors++;
      end
      if (in_meta_o !== exp_meta[0]) begin
        $display("MISMATCH %s meta expected %h actual %h", exp_name[0], exp_meta[0],
                 in_meta_o);
        rsp_errors++;
      end
      void'(exp_data.pop_front());
      void'(exp_meta.pop_front());
      void'(exp_name.pop_front());
      void'(exp_stall.pop_front());
    end
  endtask

  task automatic finish_run();
    $display("errors: response %0d, memory %0d, timeouts %0d", rsp_errors, mem_errors,
             timeouts);
    if (rsp_errors == 0 && mem_errors == 0 && timeouts == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  // ------------------------------------------------------------------------
  // response side, ready held low for the entry's stall count
  // ------------------------------------------------------------------------

  initial begin
    wait_cnt   = 0;
    ready_next = 1'b0;
    forever begin
      @(negedge clk_i);
      if (in_valid_o && in_ready_i) begin
        check_response();
        wait_cnt   = 0;
        ready_next = 1'b0;
      end else if (in_valid_o) begin
        if (exp_stall.size() == 0 || wait_cnt >= exp_stall[0]) ready_next = 1'b1;
        else wait_cnt++;
      end else begin
        ready_next = 1'b0;
      end
      @(posedge clk_i);
      in_ready_i <= ready_next;
    end
  end

  // ------------------------------------------------------------------------
  // request side
  // ------------------------------------------------------------------------

  initial begin
    int cnt;
    in_valid_i   = 1'b0;
    in_address_i = '0;
    in_amo_i     = '0;
    in_write_i   = 1'b0;
    in_wdata_i   = '0;
    in_meta_i    = '0;
    in_be_i      = '0;
    in_ready_i   = 1'b0;
    out_rdata_i  = '0;
    rsp_errors   = 0;
    mem_errors   = 0;
    timeouts     = 0;
    for (int a = 0; a < 2**addr_width; a++) begin
      sram_mem[a] = fill_word(a);
      ref_mem[a]  = fill_word(a);
    end
    for (int i = 0; i < num_resv; i++) rv[i] = 1'b0;
    build_table();

    cnt = 0;
    while (rst_ni !== 1'b1 && cnt < timeout_cycles) begin
      @(posedge clk_i);
      cnt++;
    end
    if (rst_ni !== 1'b1) begin
      $display("reset never released");
      timeouts++;
    end

    foreach (table_q[k]) begin
      if (timeouts != 0) break;
      @(posedge clk_i);
      in_valid_i   <= 1'b1;
      in_address_i <= table_q[k].addr;
      in_amo_i     <= table_q[k].op;
      in_write_i   <= table_q[k].write;
      in_wdata_i   <= table_q[k].wdata;
      in_be_i      <= table_q[k].be;
      in_meta_i    <= table_q[k].meta;
      cnt = 0;
      @(negedge clk_i);
      while (!in_ready_o && cnt < timeout_cycles) begin
        @(negedge clk_i);
        cnt++;
      end
      if (!in_ready_o) begin
        $display("request %s was never accepted", table_q[k].name);
        timeouts++;
      end else begin
        apply_reference(table_q[k]);
      end
    end
    @(posedge clk_i);
    in_valid_i <= 1'b0;

    cnt = 0;
    while (exp_data.size() != 0 && cnt < timeout_cycles) begin
      @(negedge clk_i);
      cnt++;
    end
    if (exp_data.size() != 0) begin
      $display("%0d responses never arrived", exp_data.size());
      timeouts++;
    end

    for (int a = 0; a < 2**addr_width; a++) begin
      if (sram_mem[a] !== ref_mem[a]) begin
        $display("MISMATCH mem_%h expected %h actual %h", a[15:0], ref_mem[a], sram_mem[a]);
        mem_errors++;
      end
    end
    finish_run();
  end

endmodule

/* verilog.f */
tcdm_bus_pkg.sv
amo_pkg.sv
tcdm_req_if.sv
tcdm_rsp_if.sv
tcdm_reservation.sv
tcdm_decode.sv
tcdm_amo_alu.sv
tcdm_execute.sv
tcdm_result.sv
tcdm_adapter.sv
tb_clk_gen.sv
tcdm_adapter_asserts.sv
tb_tcdm_adapter.sv
